// File: files.f
video_pkg.sv
video_timing.sv
video_regs.sv
playfield_fetch.sv
vram_arbiter.sv
video_gen.sv
video_gen_properties.sv
video_gen_tb.sv

// File: playfield_fetch.sv
// One bitmap playfield at 4 bits per pixel.
// Walks the line addresses, requests VRAM words through a valid/ready port
// while the two-word buffer has room, and shifts pixels out MSB nibble first.
// color_o is registered, one cycle after the raster counters.

`timescale 1ns/1ps

module playfield_fetch (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::raster_t   raster_i,
    input  video_pkg::pf_cfg_t   cfg_i,
    input  video_pkg::color_t    border_color_i,
    output video_pkg::vram_req_t req_o,
    input  logic                 ready_i,
    input  logic                 rvalid_i,
    input  video_pkg::word_t     rdata_i,
    output video_pkg::color_t    color_o
);

    video_pkg::addr_t line_base;                // first word of the current line
    video_pkg::addr_t fetch_addr;
    logic [$clog2(video_pkg::WORDS_PER_LINE):0] words_req;
    video_pkg::word_t buf_q [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count_q;
    logic [1:0]       occ_next;
    video_pkg::word_t shift_q;
    video_pkg::word_t cur_word;
    logic             line_start;
    logic             visible;
    logic             load;
    logic             pop;

    assign line_start = raster_i.h_count == video_pkg::hcount_t'(video_pkg::H_FETCH_BEGIN);
    assign visible    = raster_i.h_visible && raster_i.v_visible;
    assign load       = visible && ((raster_i.h_count % video_pkg::PIXELS_PER_WORD) == 0);
    assign pop        = load && (count_q != 2'd0);
    assign occ_next   = count_q + 2'(rvalid_i) - 2'(pop);   // occupancy after this cycle
    assign cur_word   = load ? buf_q[rd_ptr] : shift_q;

    // the word requested now lands next cycle, so leave room for it
    assign req_o.valid = raster_i.fetch && !cfg_i.blank && !line_start &&
                         (words_req < video_pkg::WORDS_PER_LINE) && (occ_next < 2'd2);
    assign req_o.addr  = fetch_addr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base  <= '0;
            fetch_addr <= '0;
            words_req  <= '0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count_q    <= '0;
        end else begin
            if (raster_i.end_of_frame) begin
                line_base <= cfg_i.start_addr;
            end else if (raster_i.end_of_line && raster_i.v_visible) begin
                line_base <= line_base + cfg_i.line_len;
            end

            if (line_start) begin
                // line 0 is prefetched before end_of_frame loads line_base
                fetch_addr <= (raster_i.v_count == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1))
                              ? cfg_i.start_addr : line_base + cfg_i.line_len;
                words_req  <= '0;
                wr_ptr     <= 1'b0;
                rd_ptr     <= 1'b0;
                count_q    <= '0;
            end else begin
                if (req_o.valid && ready_i) begin
                    fetch_addr <= fetch_addr + 1'b1;
                    words_req  <= words_req + 1'b1;
                end
                if (rvalid_i) begin
                    wr_ptr <= ~wr_ptr;
                end
                if (pop) begin
                    rd_ptr <= ~rd_ptr;
                end
                count_q <= occ_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            buf_q[wr_ptr] <= rdata_i;
        end
        if (visible) begin
            shift_q <= {cur_word[11:0], 4'h0};          // next nibble to the top
        end
        color_o <= cfg_i.blank ? border_color_i
                               : cfg_i.colorbase ^ video_pkg::color_t'(cur_word[15:12]);
    end

endmodule

// File: video_gen.sv
// Top level of the bitmap video generator.
// Connects raster timing, the register file, two playfields and the VRAM
// arbiter, and registers the colour outputs with the optional A/B swap so
// they line up with dv_de_o.

`timescale 1ns/1ps

module video_gen (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              reg_wr_en_i,
    input  logic [5:0]        reg_num_i,
    input  video_pkg::word_t  reg_data_i,
    output video_pkg::word_t  reg_data_o,
    output logic              video_intr_o,
    output logic              vram_sel_o,
    output video_pkg::addr_t  vram_addr_o,
    input  video_pkg::word_t  vram_data_i,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              dv_de_o,
    output video_pkg::color_t color_a_o,
    output video_pkg::color_t color_b_o
);

    video_pkg::raster_t   raster;
    video_pkg::pf_cfg_t   pa_cfg;
    video_pkg::pf_cfg_t   pb_cfg;
    video_pkg::color_t    border_color;
    logic                 colorswap;
    video_pkg::vram_req_t req_a;
    video_pkg::vram_req_t req_b;
    logic                 ready_a;
    logic                 ready_b;
    logic                 rvalid_a;
    logic                 rvalid_b;
    video_pkg::color_t    pa_color;
    video_pkg::color_t    pb_color;

    video_timing timing (
        .clk      (clk),
        .reset_i  (reset_i),
        .raster_o (raster),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .dv_de_o  (dv_de_o)
    );

    video_regs regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_en_i    (reg_wr_en_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .reg_data_o     (reg_data_o),
        .raster_i       (raster),
        .pf_a_cfg_o     (pa_cfg),
        .pf_b_cfg_o     (pb_cfg),
        .border_color_o (border_color),
        .colorswap_o    (colorswap),
        .video_intr_o   (video_intr_o)
    );

    playfield_fetch pf_a (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .cfg_i          (pa_cfg),
        .border_color_i (border_color),
        .req_o          (req_a),
        .ready_i        (ready_a),
        .rvalid_i       (rvalid_a),
        .rdata_i        (vram_data_i),
        .color_o        (pa_color)
    );

    playfield_fetch pf_b (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .cfg_i          (pb_cfg),
        .border_color_i (border_color),
        .req_o          (req_b),
        .ready_i        (ready_b),
        .rvalid_i       (rvalid_b),
        .rdata_i        (vram_data_i),
        .color_o        (pb_color)
    );

    vram_arbiter arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_a_i     (req_a),
        .req_b_i     (req_b),
        .ready_a_o   (ready_a),
        .ready_b_o   (ready_b),
        .rvalid_a_o  (rvalid_a),
        .rvalid_b_o  (rvalid_b),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o)
    );

    // second pipeline stage, matches the sync delay
    always_ff @(posedge clk) begin
        color_a_o <= colorswap ? pb_color : pa_color;
        color_b_o <= colorswap ? pa_color : pb_color;
    end

endmodule

// File: video_gen_properties.sv
// Concurrent checks on VRAM arbitration and the vertical-blank interrupt.
// Bound into video_gen by the testbench; fail_count is read back at the end of the run.

`timescale 1ns/1ps

module video_gen_properties (
    input logic                 clk,
    input logic                 reset_i,
    input logic                 ready_b_i,
    input video_pkg::vram_req_t req_b_i,
    input logic                 video_intr_i
);

    int fail_count = 0;

    // a stalled B request must hold its address
    b_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
        (req_b_i.valid && !ready_b_i) |=> (req_b_i.addr == $past(req_b_i.addr)))
        else begin
            fail_count++;
            $error("playfield B changed its address while waiting for ready");
        end

    intr_single: assert property (@(posedge clk) disable iff (reset_i)
        video_intr_i |=> !video_intr_i)
        else begin
            fail_count++;
            $error("video interrupt stayed high for more than one cycle");
        end

endmodule

// File: video_gen_tb.sv
// Testbench for the bitmap video generator.
// Drives the register port on falling edges, models a one-cycle VRAM, and
// checks readback, pixel streams of both playfields, blank/swap and frame
// structure against a reference model of the display rules.

`timescale 1ns/1ps

module video_gen_tb;

    localparam int FRAME_CYCLES   = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int TIMEOUT_CYCLES = 4000;       // reset, register traffic, about six frames
    localparam logic [5:0] REG_LIST [7] = '{
        video_pkg::XR_VID_CTRL, video_pkg::XR_PA_GFX_CTRL, video_pkg::XR_PA_DISP_ADDR,
        video_pkg::XR_PA_LINE_LEN, video_pkg::XR_PB_GFX_CTRL, video_pkg::XR_PB_DISP_ADDR,
        video_pkg::XR_PB_LINE_LEN
    };

    logic              clk;
    logic              reset_i;
    logic              reg_wr_en_i;
    logic [5:0]        reg_num_i;
    video_pkg::word_t  reg_data_i;
    video_pkg::word_t  reg_data_o;
    logic              video_intr_o;
    logic              vram_sel_o;
    video_pkg::addr_t  vram_addr_o;
    video_pkg::word_t  vram_data_i = '0;
    logic              hsync_o;
    logic              vsync_o;
    logic              dv_de_o;
    video_pkg::color_t color_a_o;
    video_pkg::color_t color_b_o;

    video_pkg::word_t   vram_mem [4096];
    logic               rd_pending = 1'b0;      // word owed on the next cycle
    video_pkg::addr_t   rd_addr;
    video_pkg::pf_cfg_t model_a;
    video_pkg::pf_cfg_t model_b;
    video_pkg::color_t  model_border;
    logic               model_swap;
    int                 errors = 0;
    int                 cycle_count;
    video_pkg::word_t   rd_value;
    video_pkg::word_t   wr_value;

    video_gen dut (.*);

    bind video_gen video_gen_properties props (
        .clk          (clk),
        .reset_i      (reset_i),
        .ready_b_i    (ready_b),
        .req_b_i      (req_b),
        .video_intr_i (video_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // VRAM answers one cycle after the select
    always @(negedge clk) begin
        vram_data_i <= rd_pending ? vram_mem[rd_addr[11:0]] : '0;
        rd_pending  <= vram_sel_o;
        rd_addr     <= vram_addr_o;
    end

    task automatic check_eq(input string test_name, input logic [15:0] expected,
                            input logic [15:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("FAIL %s: expected %0h, got %0h", test_name, expected, actual);
        end
    endtask

    task automatic write_reg(input logic [5:0] num, input video_pkg::word_t value);
        reg_wr_en_i = 1'b1;
        reg_num_i   = num;
        reg_data_i  = value;
        @(negedge clk);
        reg_wr_en_i = 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] num, output video_pkg::word_t value);
        reg_num_i = num;
        @(negedge clk);
        value = reg_data_o;
    endtask

    function automatic video_pkg::word_t implemented_bits(input logic [5:0] num);
        case (num)
            video_pkg::XR_VID_CTRL:                            return 16'h80FF;
            video_pkg::XR_PA_GFX_CTRL, video_pkg::XR_PB_GFX_CTRL: return 16'hFF80;
            default:                                           return 16'hFFFF;
        endcase
    endfunction

    function automatic video_pkg::color_t pixel_model(input video_pkg::pf_cfg_t cfg,
                                                      input int line, input int px);
        video_pkg::addr_t addr;
        video_pkg::word_t word;
        logic [3:0]       nibble;
        addr = cfg.start_addr + video_pkg::addr_t'(line) * cfg.line_len +
               video_pkg::addr_t'(px / video_pkg::PIXELS_PER_WORD);
        word   = vram_mem[addr[11:0]];
        nibble = word[15 - 4 * (px % video_pkg::PIXELS_PER_WORD) -: 4];
        return cfg.blank ? model_border : cfg.colorbase ^ {4'h0, nibble};
    endfunction

    task automatic random_pf(output video_pkg::pf_cfg_t cfg, input logic blank);
        cfg.blank      = blank;
        cfg.colorbase  = video_pkg::color_t'($urandom);
        cfg.start_addr = video_pkg::addr_t'($urandom);
        cfg.line_len   = video_pkg::word_t'($urandom);
    endtask

    task automatic apply_config();
        write_reg(video_pkg::XR_VID_CTRL, {model_swap, 7'b0, model_border});
        write_reg(video_pkg::XR_PA_GFX_CTRL, {model_a.colorbase, model_a.blank, 7'b0});
        write_reg(video_pkg::XR_PA_DISP_ADDR, model_a.start_addr);
        write_reg(video_pkg::XR_PA_LINE_LEN, model_a.line_len);
        write_reg(video_pkg::XR_PB_GFX_CTRL, {model_b.colorbase, model_b.blank, 7'b0});
        write_reg(video_pkg::XR_PB_DISP_ADDR, model_b.start_addr);
        write_reg(video_pkg::XR_PB_LINE_LEN, model_b.line_len);
    endtask

    // skips to the next interrupt, then checks one whole frame
    task automatic check_frame(input string test_name);
        int                pix;
        int                hs_count;
        int                vs_count;
        int                intr_count;
        logic              hs_prev;
        video_pkg::color_t pa;
        video_pkg::color_t pb;
        pix        = 0;
        hs_count   = 0;
        vs_count   = 0;
        intr_count = 0;
        do @(negedge clk); while (!video_intr_o);
        hs_prev = hsync_o;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (dv_de_o) begin
                pa = pixel_model(model_a, pix / video_pkg::H_VISIBLE, pix % video_pkg::H_VISIBLE);
                pb = pixel_model(model_b, pix / video_pkg::H_VISIBLE, pix % video_pkg::H_VISIBLE);
                check_eq({test_name, " color_a"}, model_swap ? pb : pa, color_a_o);
                check_eq({test_name, " color_b"}, model_swap ? pa : pb, color_b_o);
                pix++;
            end
            if (hsync_o && !hs_prev) hs_count++;
            hs_prev = hsync_o;
            if (vsync_o) vs_count++;        // one whole line of vsync
            if (video_intr_o) intr_count++;
        end
        check_eq({test_name, " dv_de cycles"}, video_pkg::H_VISIBLE * video_pkg::V_VISIBLE, pix);
        check_eq({test_name, " hsync pulses"}, video_pkg::V_TOTAL, hs_count);
        check_eq({test_name, " vsync cycles"}, video_pkg::H_TOTAL, vs_count);
        check_eq({test_name, " interrupts"}, 1, intr_count);
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_wr_en_i = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        void'($urandom(94));
        for (int i = 0; i < 4096; i++) begin
            vram_mem[i] = video_pkg::word_t'($urandom);
        end
        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        // register readback
        for (int round = 0; round < 2; round++) begin
            foreach (REG_LIST[i]) begin
                wr_value = video_pkg::word_t'($urandom);
                write_reg(REG_LIST[i], wr_value);
                read_reg(REG_LIST[i], rd_value);
                check_eq("readback", wr_value & implemented_bits(REG_LIST[i]), rd_value);
            end
        end
        repeat (4) begin
            read_reg(video_pkg::XR_SCANLINE, rd_value);
            assert (rd_value < video_pkg::V_TOTAL)
            else begin
                errors++;
                $display("FAIL scanline: expected below %0h, got %0h", video_pkg::V_TOTAL, rd_value);
            end
            repeat (7) @(negedge clk);
        end

        // playfield A alone
        model_border = video_pkg::color_t'($urandom);
        model_swap   = 1'b0;
        random_pf(model_a, 1'b0);
        random_pf(model_b, 1'b1);
        apply_config();
        check_frame("playfield_a");

        // both playfields share the port
        random_pf(model_a, 1'b0);
        random_pf(model_b, 1'b0);
        apply_config();
        check_frame("shared_memory");

        // A blanked and streams swapped
        model_border = video_pkg::color_t'($urandom);
        model_swap   = 1'b1;
        random_pf(model_a, 1'b1);
        random_pf(model_b, 1'b0);
        apply_config();
        check_frame("blank_swap");

        $display("checks failed: %0d, assertion failures: %0d", errors, dut.props.fail_count);
        if (errors == 0 && dut.props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks failed: %0d, assertion failures: %0d", errors, dut.props.fail_count);
        $display("Test failed");
        $finish;
    end

endmodule

// File: video_pkg.sv
// Shared types, raster sizes and register numbers for the bitmap video generator.
// Every RTL file refers to these by scoped name (video_pkg::name).
// The raster is tiny on purpose so that whole frames simulate quickly.

package video_pkg;

    typedef logic [15:0] word_t;                // VRAM data word
    typedef logic [15:0] addr_t;                // VRAM word address
    typedef logic [7:0]  color_t;               // palette index
    typedef logic [5:0]  hcount_t;
    typedef logic [3:0]  vcount_t;

    // raster
    localparam int H_VISIBLE       = 32;
    localparam int H_TOTAL         = 48;
    localparam int V_VISIBLE       = 8;
    localparam int V_TOTAL         = 12;
    localparam int H_SYNC_START    = 36;        // inside horizontal blank
    localparam int H_SYNC_END      = 40;
    localparam int V_SYNC_LINE     = 9;         // inside vertical blank

    localparam int PIXELS_PER_WORD = 4;         // 4 bpp
    localparam int WORDS_PER_LINE  = H_VISIBLE / PIXELS_PER_WORD;
    localparam int H_FETCH_BEGIN   = H_TOTAL - 12;  // prefetch lead before the next line
    localparam int PIXEL_LATENCY   = 2;         // counters to pins

    // register numbers
    localparam logic [5:0] XR_VID_CTRL     = 6'h00;
    localparam logic [5:0] XR_SCANLINE     = 6'h01;
    localparam logic [5:0] XR_PA_GFX_CTRL  = 6'h10;
    localparam logic [5:0] XR_PA_DISP_ADDR = 6'h12;
    localparam logic [5:0] XR_PA_LINE_LEN  = 6'h13;
    localparam logic [5:0] XR_PB_GFX_CTRL  = 6'h18;
    localparam logic [5:0] XR_PB_DISP_ADDR = 6'h1A;
    localparam logic [5:0] XR_PB_LINE_LEN  = 6'h1B;

    typedef struct packed {
        logic   blank;                          // show border colour only
        color_t colorbase;                      // XOR'd into each pixel
        addr_t  start_addr;
        word_t  line_len;                       // words added per line
    } pf_cfg_t;

    typedef struct packed {
        hcount_t h_count;
        vcount_t v_count;
        logic    h_visible;
        logic    v_visible;
        logic    end_of_line;
        logic    end_of_frame;
        logic    end_of_visible;                // last pixel of last visible line
        logic    fetch;                         // memory fetch window
    } raster_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } vram_req_t;

endpackage

// File: video_regs.sv
// Video register file.
// Writes land the cycle after reg_wr_en_i; reads are registered, so data
// appears one cycle after reg_num_i. Holds both playfield configurations,
// the border colour and A/B swap, and raises the vertical-blank interrupt.

`timescale 1ns/1ps

module video_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_en_i,
    input  logic [5:0]          reg_num_i,
    input  video_pkg::word_t    reg_data_i,
    output video_pkg::word_t    reg_data_o,
    input  video_pkg::raster_t  raster_i,
    output video_pkg::pf_cfg_t  pf_a_cfg_o,
    output video_pkg::pf_cfg_t  pf_b_cfg_o,
    output video_pkg::color_t   border_color_o,
    output logic                colorswap_o,
    output logic                video_intr_o
);

    video_pkg::word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pf_a_cfg_o     <= '0;
            pf_b_cfg_o     <= '0;
            border_color_o <= '0;
            colorswap_o    <= 1'b0;
            video_intr_o   <= 1'b0;
        end else begin
            video_intr_o <= raster_i.end_of_visible;    // one pulse per frame
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    video_pkg::XR_VID_CTRL: begin
                        colorswap_o    <= reg_data_i[15];
                        border_color_o <= reg_data_i[7:0];
                    end
                    video_pkg::XR_PA_GFX_CTRL: begin
                        pf_a_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_a_cfg_o.blank     <= reg_data_i[7];
                    end
                    video_pkg::XR_PA_DISP_ADDR: pf_a_cfg_o.start_addr <= reg_data_i;
                    video_pkg::XR_PA_LINE_LEN:  pf_a_cfg_o.line_len   <= reg_data_i;
                    video_pkg::XR_PB_GFX_CTRL: begin
                        pf_b_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_b_cfg_o.blank     <= reg_data_i[7];
                    end
                    video_pkg::XR_PB_DISP_ADDR: pf_b_cfg_o.start_addr <= reg_data_i;
                    video_pkg::XR_PB_LINE_LEN:  pf_b_cfg_o.line_len   <= reg_data_i;
                    default: begin
                    end                                 // scanline and unmapped are read-only
                endcase
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_num_i)
            video_pkg::XR_VID_CTRL:     rd_data = {colorswap_o, 7'b0, border_color_o};
            video_pkg::XR_SCANLINE:     rd_data = video_pkg::word_t'(raster_i.v_count);
            video_pkg::XR_PA_GFX_CTRL:  rd_data = {pf_a_cfg_o.colorbase, pf_a_cfg_o.blank, 7'b0};
            video_pkg::XR_PA_DISP_ADDR: rd_data = pf_a_cfg_o.start_addr;
            video_pkg::XR_PA_LINE_LEN:  rd_data = pf_a_cfg_o.line_len;
            video_pkg::XR_PB_GFX_CTRL:  rd_data = {pf_b_cfg_o.colorbase, pf_b_cfg_o.blank, 7'b0};
            video_pkg::XR_PB_DISP_ADDR: rd_data = pf_b_cfg_o.start_addr;
            video_pkg::XR_PB_LINE_LEN:  rd_data = pf_b_cfg_o.line_len;
            default:                    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_data_o <= '0;
        end else begin
            reg_data_o <= rd_data;
        end
    end

endmodule

// File: video_timing.sv
// Raster timing for the video generator.
// Counts pixels and lines, decodes visible, end-of-line/frame and the fetch
// window, and produces sync and data-enable delayed to match the pixel path.

`timescale 1ns/1ps

module video_timing (
    input  logic                clk,
    input  logic                reset_i,
    output video_pkg::raster_t  raster_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    video_pkg::hcount_t h_count;
    video_pkg::vcount_t v_count;
    logic               last_pixel;
    logic               last_line;
    logic               pre_line;
    logic               h_vis;
    logic               v_vis;
    logic [2:0]         sync_raw;
    logic [video_pkg::PIXEL_LATENCY-1:0][2:0] sync_pipe;

    assign last_pixel = h_count == video_pkg::hcount_t'(video_pkg::H_TOTAL - 1);
    assign last_line  = v_count == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1);
    assign h_vis      = h_count < video_pkg::hcount_t'(video_pkg::H_VISIBLE);
    assign v_vis      = v_count < video_pkg::vcount_t'(video_pkg::V_VISIBLE);
    // lines that are followed by a visible line
    assign pre_line   = last_line || (v_count < video_pkg::vcount_t'(video_pkg::V_VISIBLE - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            // start in the last blank line so line 0 gets its prefetch
            v_count <= video_pkg::vcount_t'(video_pkg::V_TOTAL - 1);
        end else if (last_pixel) begin
            h_count <= '0;
            v_count <= last_line ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    always_comb begin
        raster_o.h_count        = h_count;
        raster_o.v_count        = v_count;
        raster_o.h_visible      = h_vis;
        raster_o.v_visible      = v_vis;
        raster_o.end_of_line    = last_pixel;
        raster_o.end_of_frame   = last_pixel && last_line;
        raster_o.end_of_visible = last_pixel &&
                                  (v_count == video_pkg::vcount_t'(video_pkg::V_VISIBLE - 1));
        raster_o.fetch          = (h_vis && v_vis) ||
            (h_count >= video_pkg::hcount_t'(video_pkg::H_FETCH_BEGIN) && pre_line);
    end

    assign sync_raw[2] = (h_count >= video_pkg::hcount_t'(video_pkg::H_SYNC_START)) &&
                         (h_count < video_pkg::hcount_t'(video_pkg::H_SYNC_END));
    assign sync_raw[1] = v_count == video_pkg::vcount_t'(video_pkg::V_SYNC_LINE);
    assign sync_raw[0] = h_vis && v_vis;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_pipe <= '0;
        end else begin
            sync_pipe <= {sync_pipe[video_pkg::PIXEL_LATENCY-2:0], sync_raw};
        end
    end

    assign {hsync_o, vsync_o, dv_de_o} = sync_pipe[video_pkg::PIXEL_LATENCY-1];

endmodule

// File: vram_arbiter.sv
// Fixed-priority VRAM port sharing between playfield A and playfield B.
// A is granted whenever it is valid; B only when A is idle. The shared
// word on vram_data_i is flagged to its owner one cycle after the grant.

`timescale 1ns/1ps

module vram_arbiter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::vram_req_t req_a_i,
    input  video_pkg::vram_req_t req_b_i,
    output logic                 ready_a_o,
    output logic                 ready_b_o,
    output logic                 rvalid_a_o,
    output logic                 rvalid_b_o,
    output logic                 vram_sel_o,
    output video_pkg::addr_t     vram_addr_o
);

    logic grant_a;
    logic grant_b;

    assign ready_a_o   = req_a_i.valid;             // A never waits
    assign ready_b_o   = !req_a_i.valid;
    assign grant_a     = req_a_i.valid && ready_a_o;
    assign grant_b     = req_b_i.valid && ready_b_o;

    assign vram_sel_o  = grant_a || grant_b;
    assign vram_addr_o = grant_a ? req_a_i.addr : req_b_i.addr;

    // remember who owns the word coming back next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rvalid_a_o <= 1'b0;
            rvalid_b_o <= 1'b0;
        end else begin
            rvalid_a_o <= grant_a;
            rvalid_b_o <= grant_b;
        end
    end

endmodule
